// File: hdl/freq_mon_pkg.sv
// Frequency monitor shared definitions
// Widths, channel count, window length, per-channel limits and status codes

package freq_mon_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	// Monitored test clocks
	localparam int NUM_CH = 3;
	// Width of the channel select
	localparam int CH_SEL_W = 2;

	// Prescaler bits in each test domain, divide by 4
	localparam int LGNAVGS = 2;
	// Reported count width
	localparam int BUSW = 16;
	// Edge counter width, the prescale bits are appended on output
	localparam int CNT_W = BUSW - LGNAVGS;

	////////////////////////////////////////////////////////////////////////////
	// Measurement window
	////////////////////////////////////////////////////////////////////////////

	// Window length in system clocks
	localparam int GATE_CYCLES = 64;
	// Must hold GATE_CYCLES-1
	localparam int GATE_W = 7;

	////////////////////////////////////////////////////////////////////////////
	// Limits, in reported units
	////////////////////////////////////////////////////////////////////////////

	localparam logic [BUSW-1:0] LIMIT_LO [NUM_CH] = '{16'd96, 16'd96, 16'd96};
	localparam logic [BUSW-1:0] LIMIT_HI [NUM_CH] = '{16'd224, 16'd224, 16'd224};

	// Accepted deviation from nominal, two prescale units
	localparam int COUNT_TOL = 2 << LGNAVGS;

	// Per-channel status
	typedef enum logic [1:0] {
		ST_UNKNOWN = 2'd0,	// No full window seen yet
		ST_LOW     = 2'd1,	// Below LIMIT_LO
		ST_OK      = 2'd2,
		ST_HIGH    = 2'd3	// Above LIMIT_HI
	} ch_status_t;

endpackage

// File: hdl/gate_timer.sv
// Gate timer
// Free-running window counter, one-cycle gate pulse at each window boundary
`timescale 1ns/10ps

module gate_timer (
	input  logic i_sys_clk,
	input  logic i_reset,
	output logic o_gate
);

	// Position inside the current window
	logic [freq_mon_pkg::GATE_W-1:0] win_cnt;

	// Counter runs 0 .. GATE_CYCLES-1 and wraps
	// Gate is registered so it is high while the counter sits at its last value
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			win_cnt <= '0;
			o_gate  <= 1'b0;
		end else begin
			if (win_cnt == freq_mon_pkg::GATE_W'(freq_mon_pkg::GATE_CYCLES - 1))
				win_cnt <= '0;
			else
				win_cnt <= win_cnt + 1'b1;

			// Fire one cycle early, lands on the last count
			o_gate <= (win_cnt == freq_mon_pkg::GATE_W'(freq_mon_pkg::GATE_CYCLES - 2));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Windows are long, so a gate is never followed by another gate
	a_gate_single: assert property (
		@(posedge i_sys_clk) disable iff (i_reset)
		o_gate |=> !o_gate
	) else $error("gate_timer: gate high in two consecutive cycles");

endmodule

// File: hdl/clk_counter.sv
// Clock counter, one channel
// Divides the test clock, moves the divided clock into the system domain and
// counts its rising edges over each gate window
`timescale 1ns/10ps

module clk_counter (
	input  logic                          i_sys_clk,
	input  logic                          i_reset,
	input  logic                          i_tst_clk,
	input  logic                          i_gate,
	output logic [freq_mon_pkg::BUSW-1:0] o_count
);

	// Prescaler, test clock domain
	logic [freq_mon_pkg::LGNAVGS-1:0] avgs = '0;

	// Two-flop synchronizer
	(* ASYNC_REG = "TRUE" *)
	logic q_v, qq_v;

	// Synchronized MSB one cycle back
	logic qq_prev;

	// One-cycle strobe per divided test clock edge
	logic tst_posedge;

	// Running edge count and the value latched at the last gate
	logic [freq_mon_pkg::CNT_W-1:0] counter;
	logic [freq_mon_pkg::CNT_W-1:0] r_count;

	////////////////////////////////////////////////////////////////////////////
	// Test clock domain
	////////////////////////////////////////////////////////////////////////////

	// Free running, no reset in this domain
	always_ff @(posedge i_tst_clk) begin
		avgs <= avgs + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Crossing and edge detect
	////////////////////////////////////////////////////////////////////////////

	// MSB toggles at most once per 2**(LGNAVGS-1) test clocks
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			q_v  <= 1'b0;
			qq_v <= 1'b0;
		end else begin
			q_v  <= avgs[freq_mon_pkg::LGNAVGS-1];
			qq_v <= q_v;
		end
	end

	// Rising edge of the synchronized MSB
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			qq_prev     <= 1'b0;
			tst_posedge <= 1'b0;
		end else begin
			qq_prev     <= qq_v;
			tst_posedge <= qq_v && !qq_prev;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Windowed count
	////////////////////////////////////////////////////////////////////////////

	// Gate restarts the window; an edge in the gate cycle itself is dropped
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			counter <= '0;
		end else if (i_gate) begin
			counter <= '0;
		end else if (tst_posedge && (counter != '1)) begin
			// Saturate, never wrap
			counter <= counter + 1'b1;
		end
	end

	// Latch at the gate, visible from the following cycle
	always_ff @(posedge i_sys_clk) begin
		if (i_reset)
			r_count <= '0;
		else if (i_gate)
			r_count <= counter;
	end

	// Report in test clock edges, prescale bits filled with zero
	assign o_count = {r_count, {freq_mon_pkg::LGNAVGS{1'b0}}};

	// A test clock too fast for the window would pin the counter at its ceiling
	a_no_saturate: assert property (
		@(posedge i_sys_clk) disable iff (i_reset)
		(tst_posedge && !i_gate) |-> (counter != '1)
	) else $error("clk_counter: edge counter saturated, test clock too fast");

endmodule

// File: hdl/freq_checker.sv
// Frequency checker
// Sorts each channel count against its limits once per window, drops the
// first window after reset, and keeps a sticky out-of-range alarm
`timescale 1ns/10ps

module freq_checker (
	input  logic                          i_sys_clk,
	input  logic                          i_reset,
	input  logic                          i_gate,
	input  logic                          i_alarm_clr,
	input  logic [freq_mon_pkg::BUSW-1:0] i_count [freq_mon_pkg::NUM_CH],
	output logic                          o_update,
	output freq_mon_pkg::ch_status_t      o_status [freq_mon_pkg::NUM_CH],
	output logic                          o_alarm
);

	// Gate delayed by one, counts are latched by then
	logic gate_d;
	// Set after the first gate; that window started mid-way
	logic primed;
	// Classification of the counts now at the inputs
	freq_mon_pkg::ch_status_t next_status [freq_mon_pkg::NUM_CH];
	// Any channel out of range in this result
	logic any_bad;
	// Result is taken this cycle
	logic take;

	////////////////////////////////////////////////////////////////////////////
	// Window sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			gate_d <= 1'b0;
			primed <= 1'b0;
		end else begin
			gate_d <= i_gate;
			// First delayed gate only arms the checker
			if (gate_d)
				primed <= 1'b1;
		end
	end

	assign take = gate_d && primed;

	////////////////////////////////////////////////////////////////////////////
	// Classification
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		any_bad = 1'b0;
		for (int ch = 0; ch < freq_mon_pkg::NUM_CH; ch++) begin
			if (i_count[ch] < freq_mon_pkg::LIMIT_LO[ch])
				next_status[ch] = freq_mon_pkg::ST_LOW;
			else if (i_count[ch] > freq_mon_pkg::LIMIT_HI[ch])
				next_status[ch] = freq_mon_pkg::ST_HIGH;
			else
				next_status[ch] = freq_mon_pkg::ST_OK;
			if (next_status[ch] != freq_mon_pkg::ST_OK)
				any_bad = 1'b1;
		end
	end

	// Status and update pulse change together, one cycle after the delayed gate
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			o_update <= 1'b0;
			for (int ch = 0; ch < freq_mon_pkg::NUM_CH; ch++)
				o_status[ch] <= freq_mon_pkg::ST_UNKNOWN;
		end else begin
			o_update <= take;
			if (take) begin
				for (int ch = 0; ch < freq_mon_pkg::NUM_CH; ch++)
					o_status[ch] <= next_status[ch];
			end
		end
	end

	// Sticky alarm, a new out-of-range result beats a clear in the same cycle
	always_ff @(posedge i_sys_clk) begin
		if (i_reset)
			o_alarm <= 1'b0;
		else if (take && any_bad)
			o_alarm <= 1'b1;
		else if (i_alarm_clr)
			o_alarm <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// The partial first window never produces a result
	a_update_primed: assert property (
		@(posedge i_sys_clk) disable iff (i_reset)
		o_update |-> primed
	) else $error("freq_checker: update before the first full window");

	// Once a result is out, no channel falls back to unknown
	for (genvar ch = 0; ch < freq_mon_pkg::NUM_CH; ch++) begin : g_chk
		a_known_on_update: assert property (
			@(posedge i_sys_clk) disable iff (i_reset)
			o_update |-> (o_status[ch] != freq_mon_pkg::ST_UNKNOWN)
		) else $error("freq_checker: unknown status at update, channel %0d", ch);

		a_stays_known: assert property (
			@(posedge i_sys_clk) disable iff (i_reset)
			(o_status[ch] != freq_mon_pkg::ST_UNKNOWN) |=>
				(o_status[ch] != freq_mon_pkg::ST_UNKNOWN)
		) else $error("freq_checker: status returned to unknown, channel %0d", ch);
	end

endmodule

// File: hdl/freq_monitor.sv
// Multi-channel clock frequency monitor, top level
// Gate timer, one counter per test clock, checker and channel output select
`timescale 1ns/10ps

module freq_monitor (
	input  logic                              i_sys_clk,
	input  logic                              i_reset,
	input  logic [freq_mon_pkg::NUM_CH-1:0]   i_tst_clk,
	input  logic [freq_mon_pkg::CH_SEL_W-1:0] i_sel,
	input  logic                              i_alarm_clr,
	output logic [freq_mon_pkg::BUSW-1:0]     o_count,
	output freq_mon_pkg::ch_status_t          o_status,
	output logic                              o_update,
	output logic                              o_alarm
);

	// Window boundary strobe, shared by all channels
	logic gate;

	// Latched counts, one per channel
	logic [freq_mon_pkg::BUSW-1:0] count [freq_mon_pkg::NUM_CH];

	// Registered status from the checker
	freq_mon_pkg::ch_status_t status [freq_mon_pkg::NUM_CH];

	////////////////////////////////////////////////////////////////////////////
	// Window and per-channel counters
	////////////////////////////////////////////////////////////////////////////

	gate_timer gate_timer_i (
		.i_sys_clk (i_sys_clk),
		.i_reset   (i_reset),
		.o_gate    (gate)
	);

	for (genvar ch = 0; ch < freq_mon_pkg::NUM_CH; ch++) begin : g_ch
		clk_counter clk_counter_i (
			.i_sys_clk (i_sys_clk),
			.i_reset   (i_reset),
			.i_tst_clk (i_tst_clk[ch]),
			.i_gate    (gate),
			.o_count   (count[ch])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Limits and alarm
	////////////////////////////////////////////////////////////////////////////

	freq_checker freq_checker_i (
		.i_sys_clk   (i_sys_clk),
		.i_reset     (i_reset),
		.i_gate      (gate),
		.i_alarm_clr (i_alarm_clr),
		.i_count     (count),
		.o_update    (o_update),
		.o_status    (status),
		.o_alarm     (o_alarm)
	);

	// Channel select; out-of-range values show channel 0
	// Counts and status only move at a gate, so this is stable between updates
	always_comb begin
		if (i_sel < freq_mon_pkg::CH_SEL_W'(freq_mon_pkg::NUM_CH)) begin
			o_count  = count[i_sel];
			o_status = status[i_sel];
		end else begin
			o_count  = count[0];
			o_status = status[0];
		end
	end

endmodule

// File: tests/freq_monitor_tb.sv
// Frequency monitor testbench
// Runs the cases of the data file and checks counts, status, alarm and update timing
`timescale 1ns/10ps

module freq_monitor_tb;

	// DUT signals
	logic                              i_sys_clk;
	logic                              i_reset;
	logic [freq_mon_pkg::NUM_CH-1:0]   i_tst_clk;
	logic [freq_mon_pkg::CH_SEL_W-1:0] i_sel;
	logic                              i_alarm_clr;
	logic [freq_mon_pkg::BUSW-1:0]     o_count;
	freq_mon_pkg::ch_status_t          o_status;
	logic                              o_update;
	logic                              o_alarm;

	// Test clock half-periods in ns, reloaded for each case
	int half_ns [freq_mon_pkg::NUM_CH] = '{30, 30, 30};

	// Cases from the data file, NUM_CH entries per case
	int half_q [$];
	int nom_q [$];
	freq_mon_pkg::ch_status_t exp_q [$];
	int num_cases = 0;

	// Update spacing monitor and run limit
	int   cycle_cnt = 0;
	int   last_upd_cycle = -1;
	logic prev_upd = 1'b0;
	int   timeout_limit = 0;

	freq_monitor freq_monitor_i (
		.i_sys_clk   (i_sys_clk),
		.i_reset     (i_reset),
		.i_tst_clk   (i_tst_clk),
		.i_sel       (i_sel),
		.i_alarm_clr (i_alarm_clr),
		.o_count     (o_count),
		.o_status    (o_status),
		.o_update    (o_update),
		.o_alarm     (o_alarm)
	);

	////////////////////////////////////////////////////////////////////////////
	// Clocks
	////////////////////////////////////////////////////////////////////////////

	// 100 ns system clock
	initial begin
		i_sys_clk = 1'b0;
		forever #50 i_sys_clk = ~i_sys_clk;
	end

	// Each test clock free runs, new half-period takes effect on its next toggle
	for (genvar ch = 0; ch < freq_mon_pkg::NUM_CH; ch++) begin : g_tst_clk
		initial begin
			i_tst_clk[ch] = 1'b0;
			forever #(half_ns[ch]) i_tst_clk[ch] = ~i_tst_clk[ch];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	function automatic freq_mon_pkg::ch_status_t status_from_name(input string name);
		case (name)
			"LOW":   return freq_mon_pkg::ST_LOW;
			"OK":    return freq_mon_pkg::ST_OK;
			"HIGH":  return freq_mon_pkg::ST_HIGH;
			default: return freq_mon_pkg::ST_UNKNOWN;
		endcase
	endfunction

	// Status a nominal count must carry by the limit rules
	function automatic freq_mon_pkg::ch_status_t classify_nominal(input int nom, input int ch);
		if (nom < int'(freq_mon_pkg::LIMIT_LO[ch]))
			return freq_mon_pkg::ST_LOW;
		if (nom > int'(freq_mon_pkg::LIMIT_HI[ch]))
			return freq_mon_pkg::ST_HIGH;
		return freq_mon_pkg::ST_OK;
	endfunction

	// Fill the case queues, skipping comment and blank lines
	task automatic read_cases();
		int    fd;
		int    n;
		int    h [3];
		int    nom [3];
		string nm0, nm1, nm2;
		string line;
		freq_mon_pkg::ch_status_t st [3];
		fd = $fopen("tests/freq_monitor_input.txt", "r");
		assert (fd != 0) else stop_on_error("cannot open tests/freq_monitor_input.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%d %d %d %d %d %d %s %s %s",
				h[0], h[1], h[2], nom[0], nom[1], nom[2], nm0, nm1, nm2);
			assert (n == 9) else stop_on_error({"data file line is malformed: ", line});
			st[0] = status_from_name(nm0);
			st[1] = status_from_name(nm1);
			st[2] = status_from_name(nm2);
			for (int ch = 0; ch < freq_mon_pkg::NUM_CH; ch++) begin
				// Expected status must follow the limits, with room for the count tolerance
				assert (st[ch] == classify_nominal(nom[ch], ch))
					else stop_on_error($sformatf("data file case %0d channel %0d: status does not follow the limits", num_cases, ch));
				assert ((nom[ch] - int'(freq_mon_pkg::LIMIT_LO[ch]) > freq_mon_pkg::COUNT_TOL
					|| int'(freq_mon_pkg::LIMIT_LO[ch]) - nom[ch] > freq_mon_pkg::COUNT_TOL)
					&& int'(freq_mon_pkg::LIMIT_HI[ch]) - nom[ch] > freq_mon_pkg::COUNT_TOL)
					else stop_on_error($sformatf("data file case %0d channel %0d: count too close to a limit", num_cases, ch));
				half_q.push_back(h[ch]);
				nom_q.push_back(nom[ch]);
				exp_q.push_back(st[ch]);
			end
			num_cases++;
		end
		$fclose(fd);
		assert (num_cases > 0) else stop_on_error("data file holds no cases");
	endtask

	task automatic load_case(input int c);
		for (int ch = 0; ch < freq_mon_pkg::NUM_CH; ch++)
			half_ns[ch] = half_q[c * freq_mon_pkg::NUM_CH + ch];
	endtask

	// Returns at the negedge where the n-th further update pulse is seen
	task automatic wait_for_updates(input int n);
		repeat (n) begin
			@(negedge i_sys_clk);
			while (!o_update)
				@(negedge i_sys_clk);
		end
	endtask

	// Select a channel and compare its count and status with case c, channel ch
	task automatic check_channel(input int sel, input int ch, input int c);
		int diff;
		int nom;
		freq_mon_pkg::ch_status_t exp_st;
		nom    = nom_q[c * freq_mon_pkg::NUM_CH + ch];
		exp_st = exp_q[c * freq_mon_pkg::NUM_CH + ch];
		@(posedge i_sys_clk);
		i_sel <= sel[freq_mon_pkg::CH_SEL_W-1:0];
		@(negedge i_sys_clk);
		diff = int'(o_count) - nom;
		assert (diff <= freq_mon_pkg::COUNT_TOL && diff >= -freq_mon_pkg::COUNT_TOL)
			else stop_on_error($sformatf("mismatch at %0t: case %0d sel %0d count %0d, expected %0d",
				$time, c, sel, o_count, nom));
		assert (o_status == exp_st)
			else stop_on_error($sformatf("mismatch at %0t: case %0d sel %0d status %s, expected %s",
				$time, c, sel, o_status.name(), exp_st.name()));
	endtask

	// Nothing known and no alarm until the first full window is done
	task automatic check_startup();
		int n;
		n = 1;
		@(negedge i_sys_clk);
		while (!o_update) begin
			assert (o_status == freq_mon_pkg::ST_UNKNOWN)
				else stop_on_error($sformatf("mismatch at %0t: status %s before first update",
					$time, o_status.name()));
			assert (!o_alarm)
				else stop_on_error($sformatf("mismatch at %0t: alarm set before first update", $time));
			@(posedge i_sys_clk);
			i_sel <= freq_mon_pkg::CH_SEL_W'((int'(i_sel) + 1) % freq_mon_pkg::NUM_CH);
			@(negedge i_sys_clk);
			n++;
		end
		// First window is dropped, so the first pulse follows the second gate
		assert (n > freq_mon_pkg::GATE_CYCLES + 2 && n <= 2 * freq_mon_pkg::GATE_CYCLES + 3)
			else stop_on_error($sformatf("mismatch at %0t: first update at cycle %0d", $time, n));
	endtask

	task automatic clear_alarm();
		@(posedge i_sys_clk);
		i_alarm_clr <= 1'b1;
		@(posedge i_sys_clk);
		i_alarm_clr <= 1'b0;
		@(negedge i_sys_clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Update pulse width, spacing and run limit
	////////////////////////////////////////////////////////////////////////////

	always @(negedge i_sys_clk) begin
		if (i_reset === 1'b0) begin
			cycle_cnt++;
			assert (cycle_cnt < timeout_limit)
				else stop_on_error("timeout: o_update pulses stopped arriving");
			if (o_update) begin
				assert (!prev_upd)
					else stop_on_error($sformatf("mismatch at %0t: o_update wider than one cycle", $time));
				if (last_upd_cycle >= 0) begin
					assert (cycle_cnt - last_upd_cycle == freq_mon_pkg::GATE_CYCLES)
						else stop_on_error($sformatf("mismatch at %0t: updates %0d cycles apart",
							$time, cycle_cnt - last_upd_cycle));
				end
				last_upd_cycle = cycle_cnt;
			end
			prev_upd = o_update;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic bad;
		logic exp_alarm;
		i_reset     <= 1'b1;
		i_sel       <= '0;
		i_alarm_clr <= 1'b0;
		exp_alarm = 1'b0;
		read_cases();
		// Two windows per case plus the checks, with slack
		timeout_limit = (num_cases + 2) * 3 * freq_mon_pkg::GATE_CYCLES + 100;
		load_case(0);
		repeat (3) @(posedge i_sys_clk);
		i_reset <= 1'b0;
		check_startup();
		for (int c = 0; c < num_cases; c++) begin
			load_case(c);
			// First result after a change mixes old and new clocks
			wait_for_updates(2);
			bad = 1'b0;
			for (int ch = 0; ch < freq_mon_pkg::NUM_CH; ch++) begin
				check_channel(ch, ch, c);
				if (exp_q[c * freq_mon_pkg::NUM_CH + ch] != freq_mon_pkg::ST_OK)
					bad = 1'b1;
			end
			// Select 3 shows channel 0
			check_channel(freq_mon_pkg::NUM_CH, 0, c);
			if (bad)
				exp_alarm = 1'b1;
			assert (o_alarm == exp_alarm)
				else stop_on_error($sformatf("mismatch at %0t: case %0d alarm %0b, expected %0b",
					$time, c, o_alarm, exp_alarm));
			// Alarm held through a good case, then cleared
			if (exp_alarm && !bad) begin
				clear_alarm();
				exp_alarm = 1'b0;
				assert (o_alarm == 1'b0)
					else stop_on_error($sformatf("mismatch at %0t: alarm still set after clear", $time));
			end
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: tests/freq_monitor_input.txt
# Columns: half-periods in ns for ch0 ch1 ch2, nominal counts (6400 ns / period) for ch0 ch1 ch2,
# expected status for ch0 ch1 ch2 (LOW, OK or HIGH)
# The divided clock must stay below half the system clock, so no case can reach HIGH
26 28 30 123 114 107 OK OK OK
30 26 28 107 123 114 OK OK OK
28 30 26 114 107 123 OK OK OK
50 28 26 64 114 123 LOW OK OK
28 40 100 114 80 32 OK LOW LOW
26 28 30 123 114 107 OK OK OK
28 30 26 114 107 123 OK OK OK
26 26 26 123 123 123 OK OK OK
64 26 80 50 123 40 LOW OK LOW
40 40 40 80 80 80 LOW LOW LOW
30 30 30 107 107 107 OK OK OK
26 30 28 123 107 114 OK OK OK

// File: tb.f
hdl/freq_mon_pkg.sv
hdl/gate_timer.sv
hdl/clk_counter.sv
hdl/freq_checker.sv
hdl/freq_monitor.sv
tests/freq_monitor_tb.sv
